//--- sources.f
hdl/bp_pkg.sv
hdl/bp_history_table.sv
hdl/bp_counter_table.sv
hdl/bp_target_buffer.sv
hdl/bp_fetch_predict.sv
hdl/bp_update_stage.sv
hdl/branch_predictor.sv
verification/tb_branch_predictor.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the branch predictor testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=build
LOG_FILE=sim.log

verilator --binary --timing \
    -f sources.f \
    --top-module tb_branch_predictor \
    -Mdir "$BUILD_DIR" \
    -o sim_branch_predictor

"./$BUILD_DIR/sim_branch_predictor" > "$LOG_FILE" 2>&1 || true
cat "$LOG_FILE"

if grep -qF "*** FAILED ***" "$LOG_FILE"; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"

//--- verification/tb_branch_predictor.sv
`timescale 1ns/1ps

module tb_branch_predictor;

    import bp_pkg::*;

    localparam int BTB_IDX_W  = 7;
    localparam int BTB_DEPTH  = 2 ** BTB_IDX_W;
    localparam int TRAIN_LEN  = 12;
    localparam int RANDOM_LEN = 16;

    localparam pc_t BR_A      = 32'h0000_1040; // BTB slot 16
    localparam pc_t ALIAS_A   = 32'h0040_1040; // same slot, other tag
    localparam pc_t BR_B      = 32'h0000_2188; // BTB slot 98
    localparam pc_t FILLER_PC = 32'h0000_3300; // slot 64, never resolved
    localparam pc_t TGT_A     = 32'h0000_0800;
    localparam pc_t TGT_A_NEW = 32'h0000_0a24;
    localparam pc_t TGT_B     = 32'h0000_4100;

    // One table row, one clock cycle
    typedef struct packed {
        logic        rst;
        pc_t         fetch_pc;
        bp_resolve_t resolve;
        bp_predict_t exp_pred;
    } row_t;

    logic        clk_i;
    logic        rst_i;
    pc_t         fetch_pc_i;
    bp_resolve_t resolve_i;
    bp_predict_t predict_o;

    row_t   rows[$];
    integer seed;
    int     error_count = 0;
    int     check_count = 0;
    int     cycle_count = 0;
    int     cycle_limit = 0;

    branch_predictor #(
        .HIST_IDX_W (8),
        .HIST_W     (10),
        .BTB_IDX_W  (BTB_IDX_W)
    ) i_branch_predictor (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .fetch_pc_i (fetch_pc_i),
        .resolve_i  (resolve_i),
        .predict_o  (predict_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    initial begin
        while (cycle_limit == 0 || cycle_count <= cycle_limit) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("Timeout: the run did not end within %0d cycles", cycle_limit);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic check_value(input string what, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, actual, expected);
        end
    endtask

    function automatic pc_t random_pc();
        pc_t pc;
        pc = $random(seed);
        return pc & 32'hffff_fffc; // word aligned
    endfunction

    function automatic bp_resolve_t taken_resolve(pc_t pc, pc_t target);
        bp_resolve_t res;
        res.valid  = 1'b1;
        res.pc     = pc;
        res.taken  = 1'b1;
        res.target = target;
        return res;
    endfunction

    // Target buffer model replayed over rows 0..idx-1.
    // A resolve in row j lands at the end of row j+1, unless a reset row is in the way.
    // Every branch that hits here was trained taken long enough to saturate.
    function automatic bp_predict_t expected_lookup(int idx, pc_t pc);
        logic                 m_valid  [BTB_DEPTH];
        pc_t                  m_tag    [BTB_DEPTH];
        pc_t                  m_target [BTB_DEPTH];
        logic [BTB_IDX_W-1:0] slot;
        bp_resolve_t          res;
        bp_predict_t          pred;
        m_valid = '{default: 1'b0};
        for (int j = 0; j < idx; j++) begin
            if (rows[j].rst) begin
                m_valid = '{default: 1'b0};
            end else if (j > 0 && rows[j-1].resolve.valid && !rows[j-1].rst) begin
                res            = rows[j-1].resolve;
                slot           = res.pc[BTB_IDX_W+1:2];
                m_valid[slot]  = 1'b1;
                m_tag[slot]    = res.pc;
                m_target[slot] = res.target;
            end
        end
        slot         = pc[BTB_IDX_W+1:2];
        pred.taken   = m_valid[slot] && (m_tag[slot][PC_W-1:2] == pc[PC_W-1:2]);
        pred.next_pc = pred.taken ? {m_target[slot][PC_W-1:1], 1'b0} : pc + 32'd4;
        return pred;
    endfunction

    function automatic void add_row(logic rst, pc_t pc, bp_resolve_t res);
        row_t row;
        row.rst      = rst;
        row.fetch_pc = pc;
        row.resolve  = res;
        row.exp_pred = expected_lookup(rows.size(), pc);
        rows.push_back(row);
    endfunction

    // Twelve taken resolves, then one quiet row so the last update has landed
    function automatic void train_taken(pc_t branch, pc_t target, pc_t lookup_pc);
        for (int k = 0; k < TRAIN_LEN; k++) begin
            add_row(1'b0, lookup_pc, taken_resolve(branch, target));
        end
        add_row(1'b0, lookup_pc, '0);
    endfunction

    function automatic void build_table();
        // Empty buffer after reset
        add_row(1'b0, BR_A, '0);
        add_row(1'b0, BR_B, '0);
        for (int k = 0; k < 4; k++) begin
            add_row(1'b0, random_pc(), '0);
        end

        train_taken(BR_A, TGT_A, FILLER_PC);
        add_row(1'b0, BR_A, '0);
        add_row(1'b0, BR_A, '0);

        add_row(1'b0, ALIAS_A, '0); // tag mismatch
        add_row(1'b0, BR_A, '0);

        // B trains while A is looked up every cycle
        train_taken(BR_B, TGT_B, BR_A);
        add_row(1'b0, BR_B, '0);
        add_row(1'b0, BR_A, '0);
        add_row(1'b0, BR_B, taken_resolve(BR_A, TGT_A_NEW));
        add_row(1'b0, BR_B, '0);
        add_row(1'b0, BR_A, '0);
        add_row(1'b0, BR_B, '0);

        add_row(1'b1, FILLER_PC, '0); // reset clears valid bits
        add_row(1'b0, BR_A, '0);
        add_row(1'b0, BR_B, '0);
        add_row(1'b0, ALIAS_A, '0);

        for (int k = 0; k < RANDOM_LEN; k++) begin
            add_row(1'b0, random_pc(), '0);
        end
    endfunction

    initial begin
        seed       = 32'ha88582e9;
        rst_i      = 1'b1;
        fetch_pc_i = '0;
        resolve_i  = '0;
        build_table();
        cycle_limit = 2 * rows.size() + 50;

        repeat (5) @(negedge clk_i);
        rst_i = 1'b0;

        foreach (rows[i]) begin
            @(negedge clk_i);
            rst_i      = rows[i].rst;
            fetch_pc_i = rows[i].fetch_pc;
            resolve_i  = rows[i].resolve;
            #2; // lookup is combinational, settled well before the rising edge
            check_value($sformatf("row %0d taken for pc %h", i, rows[i].fetch_pc),
                        64'(predict_o.taken), 64'(rows[i].exp_pred.taken));
            check_value($sformatf("row %0d next_pc for pc %h", i, rows[i].fetch_pc),
                        64'(predict_o.next_pc), 64'(rows[i].exp_pred.next_pc));
        end

        @(negedge clk_i);
        rst_i     = 1'b0;
        resolve_i = '0;

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- hdl/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor #(
    parameter int HIST_IDX_W = 8,
    parameter int HIST_W     = 10,
    parameter int BTB_IDX_W  = 7
) (
    input  logic                   clk_i,
    input  logic                   rst_i,

    input  bp_pkg::pc_t            fetch_pc_i,
    input  bp_pkg::bp_resolve_t    resolve_i,
    output bp_pkg::bp_predict_t    predict_o
);

    import bp_pkg::*;

    // Lookup side
    logic [HIST_IDX_W-1:0] hist_raddr;
    logic [HIST_W-1:0]     hist_rdata;
    logic [HIST_W-1:0]     ctr_raddr;
    bp_counter_e           ctr_state;
    logic [BTB_IDX_W-1:0]  btb_raddr;
    logic [PC_W-1:2]       btb_tag;
    logic [PC_W-1:1]       btb_target;
    logic                  btb_valid;

    // Update side
    logic [HIST_IDX_W-1:0] hist_waddr;
    logic [HIST_W-1:0]     hist_old;
    logic                  hist_we;
    logic [HIST_W-1:0]     hist_wdata;
    logic [HIST_W-1:0]     ctr_waddr;
    logic                  ctr_we;
    logic                  ctr_taken;
    logic [BTB_IDX_W-1:0]  btb_waddr;
    logic                  btb_we;
    logic [PC_W-1:2]       btb_wtag;
    logic [PC_W-1:1]       btb_wtarget;

    bp_fetch_predict #(
        .HIST_IDX_W (HIST_IDX_W),
        .HIST_W     (HIST_W),
        .BTB_IDX_W  (BTB_IDX_W)
    ) i_fetch_predict (
        .fetch_pc_i   (fetch_pc_i),
        .hist_raddr_o (hist_raddr),
        .hist_rdata_i (hist_rdata),
        .ctr_raddr_o  (ctr_raddr),
        .btb_raddr_o  (btb_raddr),
        .btb_tag_i    (btb_tag),
        .btb_target_i (btb_target),
        .btb_valid_i  (btb_valid),
        .counter_i    (ctr_state),
        .predict_o    (predict_o)
    );

    bp_history_table #(
        .HIST_IDX_W (HIST_IDX_W),
        .HIST_W     (HIST_W)
    ) i_history_table (
        .clk_i         (clk_i),
        .lookup_addr_i (hist_raddr),
        .lookup_data_o (hist_rdata),
        .upd_addr_i    (hist_waddr),
        .upd_we_i      (hist_we),
        .upd_wdata_i   (hist_wdata),
        .upd_rdata_o   (hist_old)
    );

    bp_counter_table #(
        .HIST_W (HIST_W)
    ) i_counter_table (
        .clk_i          (clk_i),
        .lookup_addr_i  (ctr_raddr),
        .lookup_state_o (ctr_state),
        .upd_addr_i     (ctr_waddr),
        .upd_we_i       (ctr_we),
        .upd_taken_i    (ctr_taken)
    );

    bp_target_buffer #(
        .BTB_IDX_W (BTB_IDX_W)
    ) i_target_buffer (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .raddr_i   (btb_raddr),
        .tag_o     (btb_tag),
        .target_o  (btb_target),
        .valid_o   (btb_valid),
        .waddr_i   (btb_waddr),
        .we_i      (btb_we),
        .wtag_i    (btb_wtag),
        .wtarget_i (btb_wtarget)
    );

    bp_update_stage #(
        .HIST_IDX_W (HIST_IDX_W),
        .HIST_W     (HIST_W),
        .BTB_IDX_W  (BTB_IDX_W)
    ) i_update_stage (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .resolve_i    (resolve_i),
        .hist_addr_o  (hist_waddr),
        .hist_rdata_i (hist_old),
        .hist_we_o    (hist_we),
        .hist_wdata_o (hist_wdata),
        .ctr_addr_o   (ctr_waddr),
        .ctr_we_o     (ctr_we),
        .ctr_taken_o  (ctr_taken),
        .btb_addr_o   (btb_waddr),
        .btb_we_o     (btb_we),
        .btb_tag_o    (btb_wtag),
        .btb_target_o (btb_wtarget)
    );

endmodule

//--- hdl/bp_update_stage.sv
`timescale 1ns/1ps

module bp_update_stage #(
    parameter int HIST_IDX_W = 8,
    parameter int HIST_W     = 10,
    parameter int BTB_IDX_W  = 7
) (
    input  logic                       clk_i,
    input  logic                       rst_i,

    input  bp_pkg::bp_resolve_t        resolve_i,

    output logic [HIST_IDX_W-1:0]      hist_addr_o,
    input  logic [HIST_W-1:0]          hist_rdata_i,
    output logic                       hist_we_o,
    output logic [HIST_W-1:0]          hist_wdata_o,

    output logic [HIST_W-1:0]          ctr_addr_o,
    output logic                       ctr_we_o,
    output logic                       ctr_taken_o,

    output logic [BTB_IDX_W-1:0]       btb_addr_o,
    output logic                       btb_we_o,
    output logic [bp_pkg::PC_W-1:2]    btb_tag_o,
    output logic [bp_pkg::PC_W-1:1]    btb_target_o
);

    import bp_pkg::*;

    logic valid_q;
    pc_t  pc_q;
    logic taken_q;
    pc_t  target_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= resolve_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        pc_q     <= resolve_i.pc;
        taken_q  <= resolve_i.taken;
        target_q <= resolve_i.target;
    end

    // Same enable for all three tables
    assign hist_we_o = valid_q;
    assign ctr_we_o  = valid_q;
    assign btb_we_o  = valid_q;

    assign hist_addr_o  = pc_q[HIST_IDX_W+1:2];
    assign hist_wdata_o = {hist_rdata_i[HIST_W-2:0], taken_q}; // newest outcome in bit 0

    // Counter trained at the pre-update history
    assign ctr_addr_o  = hist_rdata_i;
    assign ctr_taken_o = taken_q;

    assign btb_addr_o   = pc_q[BTB_IDX_W+1:2];
    assign btb_tag_o    = pc_q[PC_W-1:2];
    assign btb_target_o = target_q[PC_W-1:1];

endmodule

//--- hdl/bp_fetch_predict.sv
`timescale 1ns/1ps

module bp_fetch_predict #(
    parameter int HIST_IDX_W = 8,
    parameter int HIST_W     = 10,
    parameter int BTB_IDX_W  = 7
) (
    input  bp_pkg::pc_t                fetch_pc_i,

    output logic [HIST_IDX_W-1:0]      hist_raddr_o,
    input  logic [HIST_W-1:0]          hist_rdata_i,
    output logic [HIST_W-1:0]          ctr_raddr_o,

    output logic [BTB_IDX_W-1:0]       btb_raddr_o,
    input  logic [bp_pkg::PC_W-1:2]    btb_tag_i,
    input  logic [bp_pkg::PC_W-1:1]    btb_target_i,
    input  logic                       btb_valid_i,

    input  bp_pkg::bp_counter_e        counter_i,
    output bp_pkg::bp_predict_t        predict_o
);

    import bp_pkg::*;

    logic tag_hit;

    assign hist_raddr_o = fetch_pc_i[HIST_IDX_W+1:2];
    assign btb_raddr_o  = fetch_pc_i[BTB_IDX_W+1:2];
    assign ctr_raddr_o  = hist_rdata_i; // history selects the counter

    assign tag_hit = btb_tag_i == fetch_pc_i[PC_W-1:2];

    // Taken needs a taken-leaning counter and a live matching entry
    assign predict_o.taken   = counter_i[1] && btb_valid_i && tag_hit;
    assign predict_o.next_pc = predict_o.taken ? {btb_target_i, 1'b0} : fetch_pc_i + 32'd4;

endmodule

//--- hdl/bp_target_buffer.sv
`timescale 1ns/1ps

module bp_target_buffer #(
    parameter int BTB_IDX_W = 7
) (
    input  logic                       clk_i,
    input  logic                       rst_i,

    input  logic [BTB_IDX_W-1:0]       raddr_i,
    output logic [bp_pkg::PC_W-1:2]    tag_o,
    output logic [bp_pkg::PC_W-1:1]    target_o,
    output logic                       valid_o,

    input  logic [BTB_IDX_W-1:0]       waddr_i,
    input  logic                       we_i,
    input  logic [bp_pkg::PC_W-1:2]    wtag_i,
    input  logic [bp_pkg::PC_W-1:1]    wtarget_i
);

    import bp_pkg::*;

    localparam int DEPTH = 2 ** BTB_IDX_W;

    logic [PC_W-1:2] tag_mem    [DEPTH]; // word address of the branch
    logic [PC_W-1:1] target_mem [DEPTH]; // halfword aligned target
    logic [DEPTH-1:0] valid_q;

    assign tag_o    = tag_mem[raddr_i];
    assign target_o = target_mem[raddr_i];
    assign valid_o  = valid_q[raddr_i];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            tag_mem[waddr_i]    <= wtag_i;
            target_mem[waddr_i] <= wtarget_i;
        end
    end

    // Valid bits are the only state cleared by reset
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (we_i) begin
            valid_q[waddr_i] <= 1'b1;
        end
    end

endmodule

//--- hdl/bp_counter_table.sv
`timescale 1ns/1ps

module bp_counter_table #(
    parameter int HIST_W = 10
) (
    input  logic                 clk_i,

    input  logic [HIST_W-1:0]    lookup_addr_i,
    output bp_pkg::bp_counter_e  lookup_state_o,

    input  logic [HIST_W-1:0]    upd_addr_i,
    input  logic                 upd_we_i,
    input  logic                 upd_taken_i
);

    import bp_pkg::*;

    localparam int DEPTH = 2 ** HIST_W;

    bp_counter_e ctr_mem [DEPTH];

    bp_counter_e old_state;
    bp_counter_e next_state;

    assign lookup_state_o = ctr_mem[lookup_addr_i];
    assign old_state      = ctr_mem[upd_addr_i];

    // Step one state toward the outcome, saturate at the strong ends
    always_comb begin
        case (old_state)
            BP_STRONG_NOT_TAKEN: begin
                next_state = upd_taken_i ? BP_WEAK_NOT_TAKEN : BP_STRONG_NOT_TAKEN;
            end
            BP_WEAK_NOT_TAKEN: begin
                next_state = upd_taken_i ? BP_WEAK_TAKEN : BP_STRONG_NOT_TAKEN;
            end
            BP_WEAK_TAKEN: begin
                next_state = upd_taken_i ? BP_STRONG_TAKEN : BP_WEAK_NOT_TAKEN;
            end
            BP_STRONG_TAKEN: begin
                next_state = upd_taken_i ? BP_STRONG_TAKEN : BP_WEAK_TAKEN;
            end
            default: begin
                // Unknown entry settles to a weak state
                next_state = upd_taken_i ? BP_WEAK_TAKEN : BP_WEAK_NOT_TAKEN;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (upd_we_i) begin
            ctr_mem[upd_addr_i] <= next_state;
        end
    end

endmodule

//--- hdl/bp_history_table.sv
`timescale 1ns/1ps

module bp_history_table #(
    parameter int HIST_IDX_W = 8,
    parameter int HIST_W     = 10
) (
    input  logic                  clk_i,

    input  logic [HIST_IDX_W-1:0] lookup_addr_i,
    output logic [HIST_W-1:0]     lookup_data_o,

    input  logic [HIST_IDX_W-1:0] upd_addr_i,
    input  logic                  upd_we_i,
    input  logic [HIST_W-1:0]     upd_wdata_i,
    output logic [HIST_W-1:0]     upd_rdata_o
);

    localparam int DEPTH = 2 ** HIST_IDX_W;

    // One outcome history per branch slot
    logic [HIST_W-1:0] hist_mem [DEPTH];

    // Both ports read asynchronously
    assign lookup_data_o = hist_mem[lookup_addr_i];
    assign upd_rdata_o   = hist_mem[upd_addr_i];

    always_ff @(posedge clk_i) begin
        if (upd_we_i) begin
            hist_mem[upd_addr_i] <= upd_wdata_i;
        end
    end

endmodule

//--- hdl/bp_pkg.sv
package bp_pkg;

    // Byte address width of the fetch side
    localparam int PC_W = 32;

    typedef logic [PC_W-1:0] pc_t;

    // 2-bit saturating counter, upper bit gives the prediction
    typedef enum logic [1:0] {
        BP_STRONG_NOT_TAKEN = 2'b00,
        BP_WEAK_NOT_TAKEN   = 2'b01,
        BP_WEAK_TAKEN       = 2'b10,
        BP_STRONG_TAKEN     = 2'b11
    } bp_counter_e;

    // Answer to a fetch lookup
    typedef struct packed {
        logic taken;
        pc_t  next_pc;
    } bp_predict_t;

    // Branch outcome reported by execute
    typedef struct packed {
        logic valid;
        pc_t  pc;
        logic taken;
        pc_t  target; // computed target, also for not-taken branches
    } bp_resolve_t;

endpackage
